// ==== tcam_pkg.sv ====
package tcam_pkg;

    // array geometry
    localparam int NUM_LANES = 8;                     // byte lanes per search word
    localparam int NUM_ROWS  = 8;                     // stored entries
    localparam int LANE_W    = 8;                     // bits per lane
    localparam int WORD_W    = NUM_LANES * LANE_W;    // full key width
    localparam int ROW_IDX_W = $clog2(NUM_ROWS);      // row number width

    // vectors with a meaning of their own
    typedef logic [LANE_W-1:0]    lane_t;     // one lane byte
    typedef logic [WORD_W-1:0]    word_t;     // search word or stored key
    typedef logic [NUM_LANES-1:0] mask_t;     // care bit per lane, 1 = compare
    typedef logic [ROW_IDX_W-1:0] row_idx_t;  // row number
    typedef logic [NUM_ROWS-1:0]  hit_vec_t;  // one bit per row

    // search broadcast, same copy goes to every row
    typedef struct packed
    {
        logic  valid;   // search strobe
        word_t key;     // word to look up
    } search_bc_t;

    // write broadcast, only the addressed row takes it
    typedef struct packed
    {
        logic     valid;        // write strobe
        row_idx_t addr;         // target row
        word_t    key;          // new key
        mask_t    mask;         // new care mask
        logic     entry_valid;  // low clears the entry
    } write_bc_t;

endpackage

// ==== and_tree_comb.sv ====
module and_tree_comb #(
    parameter int NUM_INPUT_DATA = 16,  // leaves, any count
    parameter int DATA_WIDTH     = 1    // bits per leaf, ANDed bitwise
) (
    input  logic [NUM_INPUT_DATA-1:0]            i_valid,     // per-leaf valid
    input  logic [NUM_INPUT_DATA*DATA_WIDTH-1:0] i_data_bus,  // leaf data, leaf 0 at lsb
    input  logic                                 i_en,        // gate for the whole tree
    output logic                                 o_valid,     // all leaves valid
    output logic [DATA_WIDTH-1:0]                o_data_bus   // AND of all leaves
);

    // ceiling, so odd counts still end in one root
    localparam int NUM_LEVEL = $clog2(NUM_INPUT_DATA);

    for (genvar i = 0; i <= NUM_LEVEL; i++)
    begin : lvl
        // nodes at this level, rounded up for odd counts
        localparam int NODES = (NUM_INPUT_DATA + (1 << i) - 1) >> i;

        logic [NODES-1:0]            node_valid;
        logic [NODES*DATA_WIDTH-1:0] node_data;

        if (i == 0)
        begin : g_leaf
            // leaves take the inputs, zeroed when disabled
            for (genvar j = 0; j < NODES; j++)
            begin : g_in
                assign node_valid[j] = i_valid[j] & i_en;
                assign node_data[j*DATA_WIDTH +: DATA_WIDTH] =
                    i_data_bus[j*DATA_WIDTH +: DATA_WIDTH] & {DATA_WIDTH{i_en}};
            end
        end
        else
        begin : g_node
            localparam int PREV = (NUM_INPUT_DATA + (1 << (i - 1)) - 1) >> (i - 1);

            for (genvar j = 0; j < NODES; j++)
            begin : g_gate
                if (2 * j + 1 < PREV)
                begin : g_pair
                    // both children needed for a valid pair
                    assign node_valid[j] = lvl[i-1].node_valid[2*j] &
                                           lvl[i-1].node_valid[2*j+1] & i_en;
                    assign node_data[j*DATA_WIDTH +: DATA_WIDTH] =
                        {DATA_WIDTH{node_valid[j]}} &
                        lvl[i-1].node_data[(2*j)*DATA_WIDTH +: DATA_WIDTH] &
                        lvl[i-1].node_data[(2*j+1)*DATA_WIDTH +: DATA_WIDTH];
                end
                else
                begin : g_pass
                    // odd one out, straight up a level
                    assign node_valid[j] = lvl[i-1].node_valid[2*j] & i_en;
                    assign node_data[j*DATA_WIDTH +: DATA_WIDTH] =
                        {DATA_WIDTH{node_valid[j]}} &
                        lvl[i-1].node_data[(2*j)*DATA_WIDTH +: DATA_WIDTH];
                end
            end
        end
    end

    // root of the tree
    assign o_valid    = lvl[NUM_LEVEL].node_valid[0];
    assign o_data_bus = lvl[NUM_LEVEL].node_data[DATA_WIDTH-1:0];

endmodule

// ==== search_distributor.sv ====
module search_distributor
    import tcam_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,

    // search request
    input  logic       i_search_valid,    // one-cycle strobe
    input  word_t      i_search_key,

    // write request
    input  logic       i_wr_en,           // one-cycle strobe
    input  row_idx_t   i_wr_addr,
    input  word_t      i_wr_key,
    input  mask_t      i_wr_mask,
    input  logic       i_wr_entry_valid,  // 0 clears the row

    // broadcast to all rows
    output search_bc_t o_search,
    output write_bc_t  o_write
);

    // single register stage, every row sees the same edge
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_search.valid <= 1'b0;  // payload left as is
            o_write.valid  <= 1'b0;
        end
        else
        begin
            o_search.valid <= i_search_valid;
            o_search.key   <= i_search_key;

            // write fields captured every cycle, valid qualifies them
            o_write.valid       <= i_wr_en;
            o_write.addr        <= i_wr_addr;
            o_write.key         <= i_wr_key;
            o_write.mask        <= i_wr_mask;
            o_write.entry_valid <= i_wr_entry_valid;
        end
    end

endmodule

// ==== row_matcher.sv ====
module row_matcher
    import tcam_pkg::*;
#(
    parameter row_idx_t ROW_ID = '0  // this row's address
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  search_bc_t i_search,     // broadcast search
    input  write_bc_t  i_write,      // broadcast write
    output logic       o_hit,        // registered match
    output logic       o_hit_valid   // registered search strobe
);

    word_t entry_key;     // stored key
    mask_t entry_mask;    // stored care bits
    logic  entry_valid;   // entry in use, enables the tree

    mask_t lane_match;    // per-lane equal or don't-care
    mask_t lane_valid;    // search valid on every lane
    logic  tree_valid;
    logic  tree_match;

    wire wr_sel = i_write.valid && (i_write.addr == ROW_ID);  // write aimed here

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            entry_valid <= 1'b0;  // all rows empty after reset
        else if (wr_sel)
            entry_valid <= i_write.entry_valid;
    end

    // key and mask only matter once entry_valid is set
    always_ff @(posedge i_clk)
    begin
        if (wr_sel)
        begin
            entry_key  <= i_write.key;
            entry_mask <= i_write.mask;
        end
    end

    // lane compare
    always_comb
    begin
        lane_t stored_lane;
        lane_t search_lane;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            stored_lane   = entry_key[l*LANE_W +: LANE_W];
            search_lane   = i_search.key[l*LANE_W +: LANE_W];
            lane_match[l] = (search_lane == stored_lane) || !entry_mask[l];  // masked lane passes
        end
    end

    assign lane_valid = {NUM_LANES{i_search.valid}};

    and_tree_comb #(
        .NUM_INPUT_DATA (NUM_LANES),
        .DATA_WIDTH     (1)
    ) u_and_tree (
        .i_valid    (lane_valid),
        .i_data_bus (lane_match),
        .i_en       (entry_valid),  // empty row never matches
        .o_valid    (tree_valid),
        .o_data_bus (tree_match)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_hit       <= 1'b0;
            o_hit_valid <= 1'b0;
        end
        else
        begin
            o_hit       <= tree_valid & tree_match;
            // follows the search, not the tree, so empty rows still report
            o_hit_valid <= i_search.valid;
        end
    end

endmodule

// ==== hit_collector.sv ====
module hit_collector
    import tcam_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  hit_vec_t i_hit_vec,       // raw hit per row
    input  hit_vec_t i_hit_valid,     // hit valid per row
    output logic     o_result_valid,  // one pulse per search
    output hit_vec_t o_hit_vec,
    output logic     o_hit,           // any row matched
    output row_idx_t o_hit_idx        // lowest matching row, 0 if none
);

    hit_vec_t hits;       // hits qualified by their valids
    row_idx_t first_idx;  // priority encoder output

    assign hits = i_hit_vec & i_hit_valid;

    // lowest set bit wins, scan from the top down
    always_comb
    begin
        first_idx = '0;
        for (int r = NUM_ROWS - 1; r >= 0; r--)
        begin
            if (hits[r])
                first_idx = row_idx_t'(r);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_result_valid <= 1'b0;
            o_hit_vec      <= '0;
            o_hit          <= 1'b0;
            o_hit_idx      <= '0;
        end
        else
        begin
            // every row carries the same search valid, row 0 stands for all
            o_result_valid <= i_hit_valid[0];
            o_hit_vec      <= hits;
            o_hit          <= |hits;
            o_hit_idx      <= first_idx;
        end
    end

endmodule

// ==== tcam_search_top.sv ====
module tcam_search_top
    import tcam_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,

    input  logic     i_search_valid,    // search strobe
    input  word_t    i_search_key,

    input  logic     i_wr_en,           // write strobe
    input  row_idx_t i_wr_addr,
    input  word_t    i_wr_key,
    input  mask_t    i_wr_mask,
    input  logic     i_wr_entry_valid,

    output logic     o_result_valid,    // 3 cycles after the search
    output hit_vec_t o_hit_vec,
    output logic     o_hit,
    output row_idx_t o_hit_idx
);

    search_bc_t search_bc;    // to all rows
    write_bc_t  write_bc;     // to all rows
    hit_vec_t   row_hit;      // one per row
    hit_vec_t   row_hit_valid;

    search_distributor u_distributor (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_search_valid   (i_search_valid),
        .i_search_key     (i_search_key),
        .i_wr_en          (i_wr_en),
        .i_wr_addr        (i_wr_addr),
        .i_wr_key         (i_wr_key),
        .i_wr_mask        (i_wr_mask),
        .i_wr_entry_valid (i_wr_entry_valid),
        .o_search         (search_bc),
        .o_write          (write_bc)
    );

    for (genvar r = 0; r < NUM_ROWS; r++)
    begin : g_row
        row_matcher #(
            .ROW_ID (row_idx_t'(r))
        ) u_row (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_search    (search_bc),
            .i_write     (write_bc),
            .o_hit       (row_hit[r]),
            .o_hit_valid (row_hit_valid[r])
        );
    end

    hit_collector u_collector (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_hit_vec      (row_hit),
        .i_hit_valid    (row_hit_valid),
        .o_result_valid (o_result_valid),
        .o_hit_vec      (o_hit_vec),
        .o_hit          (o_hit),
        .o_hit_idx      (o_hit_idx)
    );

endmodule

// ==== tcam_search_checker.sv ====
module tcam_search_checker
    import tcam_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst,
    input logic     i_search_valid,   // top level search strobe
    input logic     i_result_valid,
    input hit_vec_t i_hit_vec,
    input logic     i_hit,
    input row_idx_t i_hit_idx
);
    timeunit 1ns;
    timeprecision 1ps;

    // three register stages, distributor, row, collector
    a_latency : assert property (@(posedge i_clk) disable iff (i_rst)
        i_search_valid |-> ##3 i_result_valid)
        else $error("no result pulse 3 cycles after a search");

    a_no_stray : assert property (@(posedge i_clk) disable iff (i_rst)
        i_result_valid |-> $past(i_search_valid, 3))  // every pulse has a search behind it
        else $error("result pulse without a search 3 cycles earlier");

    a_hit_or : assert property (@(posedge i_clk) disable iff (i_rst)
        i_hit == (|i_hit_vec))
        else $error("hit flag disagrees with the hit vector");

    a_idx_set : assert property (@(posedge i_clk) disable iff (i_rst)
        i_hit |-> i_hit_vec[i_hit_idx])
        else $error("hit index points to a clear bit");

    // nothing below the reported row may be set
    a_idx_lowest : assert property (@(posedge i_clk) disable iff (i_rst)
        i_hit |-> ((i_hit_vec & ((hit_vec_t'(1) << i_hit_idx) - hit_vec_t'(1))) == '0))
        else $error("hit index is not the lowest matching row");

endmodule

// ==== tb_tcam_search.sv ====
module tb_tcam_search
    import tcam_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;  // ns
    localparam int DRIVE_DLY   = 2;   // ns after the rising edge
    localparam int RST_CYCLES  = 4;
    localparam int RESULT_LAT  = 3;   // search strobe to result pulse
    localparam int TIMEOUT_PAD = 20;  // drain and idle margin on top of the table
    localparam int IDLE_CYCLES = 4;   // quiet tail that catches stray pulses

    typedef enum logic {OP_WRITE, OP_SEARCH} op_e;

    // one table line with expected fields used by searches only
    typedef struct {
        op_e      op;
        string    name;
        row_idx_t addr;
        word_t    key;
        mask_t    mask;
        logic     entry_valid;
        hit_vec_t exp_vec;
        logic     exp_hit;
        row_idx_t exp_idx;
    } step_t;

    logic     clk;
    logic     rst;
    logic     search_valid;
    word_t    search_key;
    logic     wr_en;
    row_idx_t wr_addr;
    word_t    wr_key;
    mask_t    wr_mask;
    logic     wr_entry_valid;
    logic     result_valid;
    hit_vec_t hit_vec;
    logic     hit;
    row_idx_t hit_idx;

    step_t  steps[$];       // stimulus table
    int     pending[$];     // table index of each search in flight
    int     issued_at[$];   // cycle each search in flight was driven
    word_t  model_key[NUM_ROWS];
    mask_t  model_mask[NUM_ROWS];
    logic   model_valid[NUM_ROWS];
    integer seed          = 32'he31e;
    int     error_count   = 0;
    int     test_count    = 0;
    int     cycle_count   = 0;
    int     timeout_limit = 1000;  // replaced once the table is built

    tcam_search_top dut_i (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_search_valid   (search_valid),
        .i_search_key     (search_key),
        .i_wr_en          (wr_en),
        .i_wr_addr        (wr_addr),
        .i_wr_key         (wr_key),
        .i_wr_mask        (wr_mask),
        .i_wr_entry_valid (wr_entry_valid),
        .o_result_valid   (result_valid),
        .o_hit_vec        (hit_vec),
        .o_hit            (hit),
        .o_hit_idx        (hit_idx)
    );

    bind tcam_search_top tcam_search_checker u_checker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_search_valid (i_search_valid),
        .i_result_valid (o_result_valid),
        .i_hit_vec      (o_hit_vec),
        .i_hit          (o_hit),
        .i_hit_idx      (o_hit_idx)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t random_word();
        word_t w;
        for (int l = 0; l < NUM_LANES; l++)
            w[l*LANE_W +: LANE_W] = lane_t'($random(seed));
        return w;
    endfunction

    // cared lanes must be equal and the entry in use
    function automatic logic row_matches(int r, word_t key);
        logic match;
        match = model_valid[r];
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if (model_mask[r][l] &&
                key[l*LANE_W +: LANE_W] != model_key[r][l*LANE_W +: LANE_W])
                match = 1'b0;
        end
        return match;
    endfunction

    task automatic store_entry(row_idx_t addr, word_t key, mask_t mask, logic ev);
        step_t s;
        model_key[addr]   = key;  // key kept even on a clear as in the row
        model_mask[addr]  = mask;
        model_valid[addr] = ev;
        s.op          = OP_WRITE;
        s.name        = $sformatf("write row %0d", addr);
        s.addr        = addr;
        s.key         = key;
        s.mask        = mask;
        s.entry_valid = ev;
        steps.push_back(s);
    endtask

    task automatic expect_search(string name, word_t key);
        step_t s;
        logic  found;
        s.op      = OP_SEARCH;
        s.name    = name;
        s.key     = key;
        s.exp_vec = '0;
        s.exp_idx = '0;  // stays 0 on a miss
        found     = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            s.exp_vec[r] = row_matches(r, key);
            if (s.exp_vec[r] && !found)
            begin
                s.exp_idx = row_idx_t'(r);  // lowest row wins
                found     = 1'b1;
            end
        end
        s.exp_hit = found;
        steps.push_back(s);
    endtask

    task automatic build_table();
        word_t k0;
        word_t k1;
        word_t k2;
        word_t k3;
        word_t probe;
        k0 = 64'h0123_4567_89ab_cdef;
        k1 = 64'hfeed_face_cafe_beef;
        k2 = 64'h1111_2222_3333_4444;
        k3 = 64'h0f1e_2d3c_4b5a_6978;
        for (int r = 0; r < NUM_ROWS; r++)
            model_valid[r] = 1'b0;  // empty after reset

        expect_search("empty array", random_word());
        store_entry(row_idx_t'(2), k0, '1, 1'b1);
        store_entry(row_idx_t'(5), k1, '1, 1'b1);
        expect_search("exact key row 2", k0);
        expect_search("exact key row 5", k1);
        for (int l = 0; l < NUM_LANES; l++)  // one wrong byte per lane
            expect_search($sformatf("lane %0d differs", l),
                          k0 ^ (word_t'(8'h5a) << (l * LANE_W)));

        // low four lanes cared and top four free
        store_entry(row_idx_t'(6), k2, mask_t'(8'h0f), 1'b1);
        probe = random_word();
        probe[4*LANE_W-1:0] = k2[4*LANE_W-1:0];
        expect_search("masked upper lanes", probe);
        expect_search("cared lane differs", k2 ^ (word_t'(8'h01) << LANE_W));

        store_entry(row_idx_t'(7), '0, '0, 1'b1);  // wildcard row
        for (int n = 0; n < 4; n++)
            expect_search($sformatf("random key %0d", n), random_word());

        // priority check then clearing moves it up
        store_entry(row_idx_t'(1), k0, '1, 1'b1);
        expect_search("rows 1 2 7 hit", k0);
        store_entry(row_idx_t'(1), k0, '1, 1'b0);
        expect_search("row 1 cleared", k0);
        store_entry(row_idx_t'(2), k0, '1, 1'b0);
        expect_search("row 2 cleared", k0);

        // write right before a search and a burst of three after it
        store_entry(row_idx_t'(0), k3, '1, 1'b1);
        expect_search("write then search", k3);
        expect_search("burst second", k1);
        expect_search("burst third", k3 ^ (word_t'(8'h80) << (7 * LANE_W)));
        store_entry(row_idx_t'(7), '0, '0, 1'b0);
        expect_search("wildcard cleared", random_word());
    endtask

    task automatic check_vec(string sig, hit_vec_t exp_val, hit_vec_t got_val);
        if (got_val !== exp_val)
        begin
            $display("FAILED %s: expected 0x%0h got 0x%0h", sig, exp_val, got_val);
            error_count++;
        end
    endtask

    task automatic check_idx(string sig, row_idx_t exp_val, row_idx_t got_val);
        if (got_val !== exp_val)
        begin
            $display("FAILED %s: expected 0x%0h got 0x%0h", sig, exp_val, got_val);
            error_count++;
        end
    endtask

    task automatic check_bit(string sig, logic exp_val, logic got_val);
        if (got_val !== exp_val)
        begin
            $display("FAILED %s: expected 0x%0h got 0x%0h", sig, exp_val, got_val);
            error_count++;
        end
    endtask

    // outputs settle after the rising edge so read them at the falling one
    always @(negedge clk)
    begin : result_monitor
        int idx;
        int sent_cycle;
        int errs_before;
        if (result_valid)
        begin
            if (pending.size() == 0)
            begin
                $display("result pulse seen with no search outstanding");
                error_count++;
            end
            else
            begin
                idx         = pending.pop_front();
                sent_cycle  = issued_at.pop_front();
                errs_before = error_count;
                if (cycle_count != sent_cycle + RESULT_LAT)
                begin
                    $display("result for %s came %0d cycles after its search, not %0d",
                             steps[idx].name, cycle_count - sent_cycle, RESULT_LAT);
                    error_count++;
                end
                check_vec("o_hit_vec", steps[idx].exp_vec, hit_vec);
                check_bit("o_hit", steps[idx].exp_hit, hit);
                check_idx("o_hit_idx", steps[idx].exp_idx, hit_idx);
                test_count++;
                if (error_count == errs_before)
                    $display("ok    %s", steps[idx].name);
                else
                    $display("bad   %s", steps[idx].name);
            end
        end
    end

    always @(posedge clk)
    begin : timeout_guard
        if (!rst)
        begin
            cycle_count++;
            if (cycle_count > timeout_limit)
            begin
                $display("timeout: results still missing after %0d cycles", cycle_count);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    initial
    begin : stimulus
        step_t st;
        rst            = 1'b1;
        search_valid   = 1'b0;
        search_key     = '0;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_key         = '0;
        wr_mask        = '0;
        wr_entry_valid = 1'b0;

        build_table();
        timeout_limit = steps.size() + TIMEOUT_PAD;

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        for (int s = 0; s < steps.size(); s++)
        begin
            st = steps[s];
            @(posedge clk);
            #DRIVE_DLY;
            search_valid = 1'b0;  // strobes last one cycle
            wr_en        = 1'b0;
            if (st.op == OP_WRITE)
            begin
                wr_en          = 1'b1;
                wr_addr        = st.addr;
                wr_key         = st.key;
                wr_mask        = st.mask;
                wr_entry_valid = st.entry_valid;
            end
            else
            begin
                search_valid = 1'b1;
                search_key   = st.key;
                pending.push_back(s);
                issued_at.push_back(cycle_count);
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        search_valid = 1'b0;
        wr_en        = 1'b0;

        while (pending.size() != 0)
            @(posedge clk);  // timeout_guard bounds this
        repeat (IDLE_CYCLES) @(posedge clk);

        $display("searches checked: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
tcam_pkg.sv
and_tree_comb.sv
search_distributor.sv
row_matcher.sv
hit_collector.sv
tcam_search_top.sv
tcam_search_checker.sv
tb_tcam_search.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
LINT     ?= --lint-only --timing --assert
TOP      ?= tb_tcam_search
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
